// ==== Makefile ====
# Verilator build and run of the CGA ALU testbench

VERILATOR ?= verilator
TOP       ?= cga_alu_tb
FLIST     ?= cga_alu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIMFLAGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(SIMFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "Simulation ended without a pass line"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cga_alu.f ====
design/alu_pkg.sv
design/alu_control.sv
design/alu_core.sv
design/alu_qshift.sv
design/alu_status.sv
design/alu_outmux.sv
design/cga_alu.sv
verification/cga_alu_properties.sv
verification/cga_alu_tb.sv

// ==== design/alu_control.sv ====
// ##############################
// ALU microcode decode
// Operand, function, carry, shift and Q controls
// ##############################

`timescale 1ns/1ps

module alu_control
  import alu_pkg::*;
(
  input  logic [8:0] csalui,    // Dest 8:6, function 5:3, source 2:0
  input  logic [1:0] cscinsel,
  input  logic [1:0] csmis,     // Shift fill
  input  logic       carry_flag,
  input  logic       link_flag,
  input  logic       f_lsb,
  input  logic       f_msb,
  input  logic       q_lsb,
  input  logic       q_msb,
  output logic [2:0] src_sel,
  output logic [2:0] fn_sel,
  output logic       cin,
  output logic       shift_dir, // 1 = up (left)
  output logic       shift_en,
  output logic       q_load,
  output logic       q_shift,
  output logic       rli,       // Enters rb bit 0 on up shift
  output logic       rri,       // Enters rb bit 15 on down shift
  output logic       qli,       // Enters q bit 0 on up shift
  output logic       qri,       // Enters q bit 15 on down shift
  output logic       bdest
);

  logic [2:0] dst;

  // Fill bit for one shifter end
  function automatic logic fill_bit(input logic [1:0] mode, input logic carry,
                                    input logic rot);
    logic bit_v;
    case (mode)
      FILL_ZERO:  bit_v = 1'b0;
      FILL_ONE:   bit_v = 1'b1;
      FILL_CARRY: bit_v = carry;
      default:    bit_v = rot;  // Rotate
    endcase
    return bit_v;
  endfunction

  assign src_sel = csalui[2:0];
  assign fn_sel  = csalui[5:3];
  assign dst     = csalui[8:6];

  // Shifting codes are 4..7, bit 1 gives the direction
  assign shift_dir = dst[1];

  always_comb begin
    shift_en = 1'b0;
    q_load   = 1'b0;
    q_shift  = 1'b0;
    bdest    = 1'b1;  // All RAM destinations
    case (dst)
      DST_QREG: begin
        q_load = 1'b1;
        bdest  = 1'b0;
      end
      DST_NOP:                bdest = 1'b0;
      DST_RAMQD, DST_RAMQU: begin
        shift_en = 1'b1;
        q_shift  = 1'b1;  // Double-length
      end
      DST_RAMD, DST_RAMU:     shift_en = 1'b1;
      default:                ;  // RAMA, RAMF pass F
    endcase
  end

  // Carry-in from the stored flags
  always_comb begin
    case (cscinsel)
      CIN_ZERO:  cin = 1'b0;
      CIN_ONE:   cin = 1'b1;
      CIN_CARRY: cin = carry_flag;
      default:   cin = link_flag;
    endcase
  end

  assign rli = fill_bit(csmis, carry_flag, f_msb);
  assign rri = fill_bit(csmis, carry_flag, f_lsb);
  assign qli = fill_bit(csmis, carry_flag, q_msb);
  assign qri = fill_bit(csmis, carry_flag, q_lsb);

endmodule

// ==== design/alu_core.sv ====
// ##############################
// ALU core
// Operand muxes, eight-function ALU, flags
// ##############################

`timescale 1ns/1ps

module alu_core
  import alu_pkg::*;
(
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  logic [DATA_W-1:0] cd,
  input  logic [DATA_W-1:0] q,
  input  logic [2:0]        src_sel,
  input  logic [2:0]        fn_sel,
  input  logic              cin,
  output logic [DATA_W-1:0] f,
  output logic              cry,
  output logic              ovf,
  output logic              zf,
  output logic              sgr
);

  logic [DATA_W-1:0] r_op;   // R operand
  logic [DATA_W-1:0] s_op;   // S operand
  logic [DATA_W-1:0] add_x;  // Adder inputs after complement
  logic [DATA_W-1:0] add_y;
  logic [DATA_W:0]   sum;    // Carry out on top
  logic              arith;

  // Source pair decode
  always_comb begin
    r_op = '0;
    s_op = '0;
    case (src_sel)
      SRC_AQ: begin r_op = a;  s_op = q; end
      SRC_AB: begin r_op = a;  s_op = b; end
      SRC_ZQ: s_op = q;
      SRC_ZB: s_op = b;
      SRC_ZA: s_op = a;
      SRC_DA: begin r_op = cd; s_op = a; end
      SRC_DQ: begin r_op = cd; s_op = q; end
      default: r_op = cd;  // DZ
    endcase
  end

  assign arith = (fn_sel == FN_ADD) || (fn_sel == FN_SUBR) || (fn_sel == FN_SUBS);

  // Subtract is add of complement plus cin
  always_comb begin
    add_x = r_op;
    add_y = s_op;
    if (fn_sel == FN_SUBR) begin
      add_x = s_op;
      add_y = ~r_op;
    end else if (fn_sel == FN_SUBS) begin
      add_y = ~s_op;
    end
  end

  assign sum = {1'b0, add_x} + {1'b0, add_y} + {{DATA_W{1'b0}}, cin};

  always_comb begin
    case (fn_sel)
      FN_OR:    f = r_op | s_op;
      FN_AND:   f = r_op & s_op;
      FN_NOTRS: f = ~r_op & s_op;
      FN_EXOR:  f = r_op ^ s_op;
      FN_EXNOR: f = ~(r_op ^ s_op);
      default:  f = sum[DATA_W-1:0];  // Arithmetic
    endcase
  end

  assign cry = arith & sum[DATA_W];
  // Same-sign operands giving a different-sign result
  assign ovf = arith & (add_x[DATA_W-1] == add_y[DATA_W-1]) &
               (sum[DATA_W-1] != add_x[DATA_W-1]);
  assign zf  = (f == '0);
  assign sgr = f[DATA_W-1];

endmodule

// ==== design/alu_outmux.sv ====
// ##############################
// Internal data bus output mux
// Select held one cycle in a flop
// ##############################

`timescale 1ns/1ps

module alu_outmux
  import alu_pkg::*;
(
  input  logic              sysclk,
  input  logic              rst_n,
  input  logic [2:0]        csidbs,
  input  logic [DATA_W-1:0] f,
  input  logic [DATA_W-1:0] q,
  input  logic [DATA_W-1:0] sts,
  input  logic [DATA_W-1:0] ea,
  input  logic [DATA_W-1:0] fidbi,
  output logic [DATA_W-1:0] idb_out
);

  localparam int HALF = DATA_W / 2;

  logic [2:0]        sel_q;  // Registered bus select
  logic [DATA_W-1:0] swap;

  always_ff @(posedge sysclk) begin
    if (!rst_n)
      sel_q <= IDBS_F;  // F on bus after reset
    else
      sel_q <= csidbs;
  end

  // Byte exchange of F
  assign swap = {f[HALF-1:0], f[DATA_W-1:HALF]};

  always_comb begin
    case (sel_q)
      IDBS_F:     idb_out = f;
      IDBS_Q:     idb_out = q;
      IDBS_STS:   idb_out = sts;
      IDBS_EA:    idb_out = ea;
      IDBS_FIDBI: idb_out = fidbi;
      IDBS_SWAP:  idb_out = swap;
      default:    idb_out = '0;  // Codes 6, 7
    endcase
  end

endmodule

// ==== design/alu_pkg.sv ====
// ##############################
// CGA ALU shared definitions
// Data width, microcode codes, status bit positions
// ##############################

package alu_pkg;

  localparam int DATA_W = 16;  // Internal bus and ALU width

  // R/S operand pairs, Z is zero and D is the cd input
  localparam logic [2:0] SRC_AQ = 3'd0;
  localparam logic [2:0] SRC_AB = 3'd1;
  localparam logic [2:0] SRC_ZQ = 3'd2;
  localparam logic [2:0] SRC_ZB = 3'd3;
  localparam logic [2:0] SRC_ZA = 3'd4;
  localparam logic [2:0] SRC_DA = 3'd5;
  localparam logic [2:0] SRC_DQ = 3'd6;
  localparam logic [2:0] SRC_DZ = 3'd7;

  // ALU functions
  localparam logic [2:0] FN_ADD   = 3'd0;  // R + S + cin
  localparam logic [2:0] FN_SUBR  = 3'd1;  // S - R
  localparam logic [2:0] FN_SUBS  = 3'd2;  // R - S
  localparam logic [2:0] FN_OR    = 3'd3;
  localparam logic [2:0] FN_AND   = 3'd4;
  localparam logic [2:0] FN_NOTRS = 3'd5;  // ~R & S
  localparam logic [2:0] FN_EXOR  = 3'd6;
  localparam logic [2:0] FN_EXNOR = 3'd7;

  // Destinations in the 2901 sense, D shifts toward bit 0
  localparam logic [2:0] DST_QREG  = 3'd0;
  localparam logic [2:0] DST_NOP   = 3'd1;
  localparam logic [2:0] DST_RAMA  = 3'd2;
  localparam logic [2:0] DST_RAMF  = 3'd3;
  localparam logic [2:0] DST_RAMQD = 3'd4;
  localparam logic [2:0] DST_RAMD  = 3'd5;
  localparam logic [2:0] DST_RAMQU = 3'd6;
  localparam logic [2:0] DST_RAMU  = 3'd7;

  // Carry-in select
  localparam logic [1:0] CIN_ZERO  = 2'd0;
  localparam logic [1:0] CIN_ONE   = 2'd1;
  localparam logic [1:0] CIN_CARRY = 2'd2;  // Stored C
  localparam logic [1:0] CIN_LINK  = 2'd3;  // Stored M

  // Shift fill select
  localparam logic [1:0] FILL_ZERO  = 2'd0;
  localparam logic [1:0] FILL_ONE   = 2'd1;
  localparam logic [1:0] FILL_CARRY = 2'd2;
  localparam logic [1:0] FILL_ROT   = 2'd3;  // Opposite end of same word

  // Internal data bus sources, 6 and 7 drive zero
  localparam logic [2:0] IDBS_F     = 3'd0;
  localparam logic [2:0] IDBS_Q     = 3'd1;
  localparam logic [2:0] IDBS_STS   = 3'd2;
  localparam logic [2:0] IDBS_EA    = 3'd3;
  localparam logic [2:0] IDBS_FIDBI = 3'd4;
  localparam logic [2:0] IDBS_SWAP  = 3'd5;

  // Status word layout
  localparam int STS_C      = 0;
  localparam int STS_O      = 1;
  localparam int STS_Z      = 2;
  localparam int STS_S      = 3;
  localparam int STS_M      = 4;  // Link
  localparam int STS_PIL_LO = 8;  // PIL in bits 11..8

endpackage

// ==== design/alu_qshift.sv ====
// ##############################
// Result shifter and Q register
// ##############################

`timescale 1ns/1ps

module alu_qshift
  import alu_pkg::*;
(
  input  logic              sysclk,
  input  logic              rst_n,
  input  logic [DATA_W-1:0] f,
  input  logic              shift_en,
  input  logic              shift_dir,  // 1 = up
  input  logic              rli,
  input  logic              rri,
  input  logic              q_load,
  input  logic              q_shift,
  input  logic              qli,
  input  logic              qri,
  output logic [DATA_W-1:0] rb,
  output logic [DATA_W-1:0] q,
  output logic              shift_out
);

  // Register bus result
  always_comb begin
    if (!shift_en)
      rb = f;
    else if (shift_dir)
      rb = {f[DATA_W-2:0], rli};  // Up
    else
      rb = {rri, f[DATA_W-1:1]};  // Down
  end

  // Bit leaving rb, goes to link
  assign shift_out = shift_dir ? f[DATA_W-1] : f[0];

  // Q register
  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      q <= '0;
    end else if (q_load) begin
      q <= f;
    end else if (q_shift) begin
      if (shift_dir)
        q <= {q[DATA_W-2:0], qli};
      else
        q <= {qri, q[DATA_W-1:1]};
    end
  end

endmodule

// ==== design/alu_status.sv ====
// ##############################
// Status register
// Flags C O Z S, link M, PIL
// ##############################

`timescale 1ns/1ps

module alu_status
  import alu_pkg::*;
(
  input  logic              sysclk,
  input  logic              rst_n,
  input  logic              ld_flags,
  input  logic              ld_pil,
  input  logic              cry,
  input  logic              ovf,
  input  logic              zf,
  input  logic              sgr,
  input  logic              shift_en,
  input  logic              shift_out,
  input  logic [3:0]        pil_in,
  output logic [DATA_W-1:0] sts
);

  logic       c_q;
  logic       o_q;
  logic       z_q;
  logic       s_q;
  logic       m_q;    // Link
  logic [3:0] pil_q;

  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      c_q   <= 1'b0;
      o_q   <= 1'b0;
      z_q   <= 1'b0;
      s_q   <= 1'b0;
      m_q   <= 1'b0;
      pil_q <= '0;
    end else begin
      if (ld_flags) begin
        c_q <= cry;
        o_q <= ovf;
        z_q <= zf;
        s_q <= sgr;
      end
      if (shift_en) m_q <= shift_out;  // Only on shift destinations
      if (ld_pil)   pil_q <= pil_in;
    end
  end

  // Pack the word, unused bits read zero
  always_comb begin
    sts                    = '0;
    sts[STS_C]             = c_q;
    sts[STS_O]             = o_q;
    sts[STS_Z]             = z_q;
    sts[STS_S]             = s_q;
    sts[STS_M]             = m_q;
    sts[STS_PIL_LO +: 4]   = pil_q;
  end

endmodule

// ==== design/cga_alu.sv ====
// ##############################
// CGA ALU top level
// Control, core, shifter, status, bus mux
// ##############################

`timescale 1ns/1ps

module cga_alu
  import alu_pkg::*;
(
  input  logic              sysclk,
  input  logic              rst_n,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  logic [DATA_W-1:0] cd,
  input  logic [8:0]        csalui,
  input  logic [1:0]        cscinsel,
  input  logic [1:0]        csmis,
  input  logic [2:0]        csidbs,
  input  logic [DATA_W-1:0] ea,
  input  logic [DATA_W-1:0] fidbi,
  input  logic              ld_flags,
  input  logic              ld_pil,
  output logic [DATA_W-1:0] f,
  output logic [DATA_W-1:0] rb,
  output logic              bdest,
  output logic              cry,
  output logic              ovf,
  output logic              zf,
  output logic              sgr,
  output logic [DATA_W-1:0] sts,
  output logic [3:0]        pil,
  output logic [DATA_W-1:0] q,
  output logic [DATA_W-1:0] idb_out
);

  logic [2:0] src_sel;
  logic [2:0] fn_sel;
  logic       cin;
  logic       shift_dir;
  logic       shift_en;
  logic       q_load;
  logic       q_shift;
  logic       rli, rri;   // rb fills
  logic       qli, qri;   // Q fills
  logic       shift_out;

  assign pil = sts[STS_PIL_LO +: 4];

  alu_control u_control (
    .csalui(csalui), .cscinsel(cscinsel), .csmis(csmis),
    .carry_flag(sts[STS_C]), .link_flag(sts[STS_M]),
    .f_lsb(f[0]), .f_msb(f[DATA_W-1]), .q_lsb(q[0]), .q_msb(q[DATA_W-1]),
    .src_sel(src_sel), .fn_sel(fn_sel), .cin(cin),
    .shift_dir(shift_dir), .shift_en(shift_en), .q_load(q_load), .q_shift(q_shift),
    .rli(rli), .rri(rri), .qli(qli), .qri(qri), .bdest(bdest)
  );

  alu_core u_core (
    .a(a), .b(b), .cd(cd), .q(q),
    .src_sel(src_sel), .fn_sel(fn_sel), .cin(cin),
    .f(f), .cry(cry), .ovf(ovf), .zf(zf), .sgr(sgr)
  );

  alu_qshift u_qshift (
    .sysclk(sysclk), .rst_n(rst_n), .f(f),
    .shift_en(shift_en), .shift_dir(shift_dir), .rli(rli), .rri(rri),
    .q_load(q_load), .q_shift(q_shift), .qli(qli), .qri(qri),
    .rb(rb), .q(q), .shift_out(shift_out)
  );

  // PIL loads from the current bus low nibble
  alu_status u_status (
    .sysclk(sysclk), .rst_n(rst_n), .ld_flags(ld_flags), .ld_pil(ld_pil),
    .cry(cry), .ovf(ovf), .zf(zf), .sgr(sgr),
    .shift_en(shift_en), .shift_out(shift_out), .pil_in(idb_out[3:0]),
    .sts(sts)
  );

  alu_outmux u_outmux (
    .sysclk(sysclk), .rst_n(rst_n), .csidbs(csidbs),
    .f(f), .q(q), .sts(sts), .ea(ea), .fidbi(fidbi),
    .idb_out(idb_out)
  );

endmodule

// ==== verification/cga_alu_properties.sv ====
// ##############################
// CGA ALU bound assertions
// Destination decode and status reset
// ##############################

`timescale 1ns/1ps

module cga_alu_properties
  import alu_pkg::*;
(
  input logic              sysclk,
  input logic              rst_n,
  input logic [8:0]        csalui,
  input logic              bdest,
  input logic [DATA_W-1:0] sts,
  input logic [DATA_W-1:0] q
);

  logic [2:0] dst;

  assign dst = csalui[8:6];  // Destination field

  // QREG and NOP leave the register bus alone
  a_bdest_low: assert property (@(posedge sysclk) disable iff (!rst_n)
    (dst == DST_QREG || dst == DST_NOP) |-> !bdest)
    else $error("bdest high on a QREG or NOP destination");

  // Shift codes 4..7 always write
  a_bdest_shift: assert property (@(posedge sysclk) disable iff (!rst_n)
    dst[2] |-> bdest)
    else $error("bdest low on a shift destination");

  a_sts_reset: assert property (@(posedge sysclk) !rst_n |=> (sts == '0))
    else $error("status word not cleared by reset");

  a_q_reset: assert property (@(posedge sysclk) !rst_n |=> (q == '0))
    else $error("Q register not cleared by reset");

endmodule

// Top ports carry both the control decode and the status word
bind cga_alu cga_alu_properties u_props (
  .sysclk(sysclk), .rst_n(rst_n), .csalui(csalui),
  .bdest(bdest), .sts(sts), .q(q)
);

// ==== verification/cga_alu_tb.sv ====
// ##############################
// CGA ALU testbench
// Random microcode against a cycle model
// ##############################

`timescale 1ns/1ps

module cga_alu_tb
  import alu_pkg::*;
();

  localparam int PERIOD   = 100;
  localparam int N_CYC    = 250;  // Cycles per random test
  localparam int N_TESTS  = 6;
  localparam int TIMEOUT  = (8 + 1 + (N_TESTS - 1) * N_CYC + 20) * PERIOD;
  localparam int K_RESET  = 0;
  localparam int K_ARITH  = 1;
  localparam int K_DEST   = 2;
  localparam int K_STATUS = 3;
  localparam int K_BUS    = 4;
  localparam int K_PIL    = 5;

  logic              sysclk, rst_n;
  logic [DATA_W-1:0] a, b, cd, ea, fidbi;
  logic [8:0]        csalui;
  logic [1:0]        cscinsel, csmis;
  logic [2:0]        csidbs;
  logic              ld_flags, ld_pil;
  logic [DATA_W-1:0] f, rb, sts, q, idb_out;
  logic              bdest, cry, ovf, zf, sgr;
  logic [3:0]        pil;

  integer            seed;
  int                errors, checks;
  logic [DATA_W-1:0] model_q, model_sts;  // Model registers
  logic [2:0]        model_sel;
  logic [DATA_W-1:0] exp_f, exp_rb, exp_idb, next_q, next_sts;
  logic              exp_cry, exp_ovf, exp_zf, exp_sgr, exp_bdest;

  cga_alu uut (
    .sysclk(sysclk), .rst_n(rst_n), .a(a), .b(b), .cd(cd), .csalui(csalui),
    .cscinsel(cscinsel), .csmis(csmis), .csidbs(csidbs), .ea(ea), .fidbi(fidbi),
    .ld_flags(ld_flags), .ld_pil(ld_pil), .f(f), .rb(rb), .bdest(bdest),
    .cry(cry), .ovf(ovf), .zf(zf), .sgr(sgr), .sts(sts), .pil(pil), .q(q),
    .idb_out(idb_out)
  );

  always #(PERIOD / 2) sysclk = ~sysclk;

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_pil(input string name, input logic [3:0] got, input logic [3:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Bit entering the vacated end of a shifted word
  function automatic logic fill_value(input logic [1:0] mode, input logic far_end);
    case (mode)
      FILL_ZERO:  return 1'b0;
      FILL_ONE:   return 1'b1;
      FILL_CARRY: return model_sts[STS_C];
      default:    return far_end;
    endcase
  endfunction

  task automatic drive_random(input int kind);
    logic [31:0] r;
    r = $random(seed);
    a = r[15:0];
    b = r[31:16];
    r = $random(seed);
    cd = r[15:0];
    ea = r[31:16];
    r = $random(seed);
    fidbi = r[15:0];
    csalui = r[24:16];
    cscinsel = r[26:25];
    csmis = r[28:27];
    csidbs = r[31:29];
    r = $random(seed);
    ld_flags = r[0];
    ld_pil = 1'b0;
    case (kind)
      K_ARITH: begin
        csalui[8:6] = DST_RAMF;  // Plain F, no shift
        ld_flags = 1'b1;  // Carry chains into CIN_CARRY
        csidbs = IDBS_F;
      end
      K_STATUS: cscinsel = {1'b1, r[1]};  // Stored C or M
      K_PIL:    ld_pil = r[2];
      default:  ;
    endcase
  endtask

  // Expected outputs and next state from current inputs and model registers
  task automatic model_eval();
    logic [DATA_W-1:0] r, s, x, y;
    logic [DATA_W:0]   total;
    logic [2:0]        dst;
    logic              c_in, up, shifting;
    int                sum_s;
    case (csalui[2:0])
      SRC_AQ:  begin r = a;  s = model_q; end
      SRC_AB:  begin r = a;  s = b;       end
      SRC_ZQ:  begin r = '0; s = model_q; end
      SRC_ZB:  begin r = '0; s = b;       end
      SRC_ZA:  begin r = '0; s = a;       end
      SRC_DA:  begin r = cd; s = a;       end
      SRC_DQ:  begin r = cd; s = model_q; end
      default: begin r = cd; s = '0;      end
    endcase
    case (cscinsel)
      CIN_ZERO:  c_in = 1'b0;
      CIN_ONE:   c_in = 1'b1;
      CIN_CARRY: c_in = model_sts[STS_C];
      default:   c_in = model_sts[STS_M];
    endcase
    x = (csalui[5:3] == FN_SUBR) ? s : r;
    y = (csalui[5:3] == FN_SUBR) ? ~r : (csalui[5:3] == FN_SUBS) ? ~s : s;
    total = {1'b0, x} + {1'b0, y} + {{DATA_W{1'b0}}, c_in};
    sum_s = int'($signed(x)) + int'($signed(y)) + int'(c_in);  // True signed sum
    exp_cry = 1'b0;
    exp_ovf = 1'b0;
    case (csalui[5:3])
      FN_OR:    exp_f = r | s;
      FN_AND:   exp_f = r & s;
      FN_NOTRS: exp_f = ~r & s;
      FN_EXOR:  exp_f = r ^ s;
      FN_EXNOR: exp_f = ~(r ^ s);
      default: begin
        exp_f = total[DATA_W-1:0];
        exp_cry = total[DATA_W];
        exp_ovf = (sum_s > 32767) || (sum_s < -32768);
      end
    endcase
    exp_zf = (exp_f == '0);
    exp_sgr = exp_f[DATA_W-1];
    dst = csalui[8:6];
    exp_bdest = (dst != DST_QREG) && (dst != DST_NOP);
    up = (dst == DST_RAMQU) || (dst == DST_RAMU);
    shifting = up || (dst == DST_RAMQD) || (dst == DST_RAMD);
    exp_rb = exp_f;
    if (shifting && up) exp_rb = {exp_f[14:0], fill_value(csmis, exp_f[15])};
    if (shifting && !up) exp_rb = {fill_value(csmis, exp_f[0]), exp_f[15:1]};
    next_q = model_q;
    if (dst == DST_QREG) next_q = exp_f;
    if (dst == DST_RAMQU) next_q = {model_q[14:0], fill_value(csmis, model_q[15])};
    if (dst == DST_RAMQD) next_q = {fill_value(csmis, model_q[0]), model_q[15:1]};
    case (model_sel)
      IDBS_F:     exp_idb = exp_f;
      IDBS_Q:     exp_idb = model_q;
      IDBS_STS:   exp_idb = model_sts;
      IDBS_EA:    exp_idb = ea;
      IDBS_FIDBI: exp_idb = fidbi;
      IDBS_SWAP:  exp_idb = {exp_f[7:0], exp_f[15:8]};
      default:    exp_idb = '0;
    endcase
    next_sts = model_sts;
    if (ld_flags) begin
      next_sts[STS_C] = exp_cry;
      next_sts[STS_O] = exp_ovf;
      next_sts[STS_Z] = exp_zf;
      next_sts[STS_S] = exp_sgr;
    end
    if (shifting) next_sts[STS_M] = up ? exp_f[15] : exp_f[0];  // Bit leaving rb
    if (ld_pil) next_sts[STS_PIL_LO +: 4] = exp_idb[3:0];
  endtask

  task automatic check_outputs();
    check_word("f", f, exp_f);
    check_word("rb", rb, exp_rb);
    check_word("q", q, model_q);
    check_word("sts", sts, model_sts);
    check_word("idb_out", idb_out, exp_idb);
    check_flag("cry", cry, exp_cry);
    check_flag("ovf", ovf, exp_ovf);
    check_flag("zf", zf, exp_zf);
    check_flag("sgr", sgr, exp_sgr);
    check_flag("bdest", bdest, exp_bdest);
    check_pil("pil", pil, model_sts[STS_PIL_LO +: 4]);
  endtask

  // Starts 5 ns after an edge, ends 5 ns after the next one
  task automatic run_cycle(input int kind);
    drive_random(kind);
    #(PERIOD - 15);  // Settled, 10 ns before the edge
    model_eval();
    if (kind == K_RESET) begin
      check_word("q", q, '0);
      check_word("sts", sts, '0);
      check_word("idb_out", idb_out, exp_f);  // Reset select is F
    end
    check_outputs();
    model_q = next_q;
    model_sts = next_sts;
    model_sel = csidbs;
    @(posedge sysclk);
    #5;
  endtask

  task automatic run_test(input string name, input int kind, input int n);
    int err0;
    err0 = errors;
    repeat (n) run_cycle(kind);
    $display("%-8s %0d cycles, %0d errors", name, n, errors - err0);
  endtask

  initial begin
    #(TIMEOUT);
    $display("Watchdog expired before the tests finished");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    seed = 32'hfdb0;
    errors = 0;
    checks = 0;
    sysclk = 1'b0;
    rst_n = 1'b0;
    {a, b, cd, ea, fidbi} = '0;
    {csalui, cscinsel, csmis, csidbs, ld_flags, ld_pil} = '0;
    model_q = '0;
    model_sts = '0;
    model_sel = IDBS_F;
    repeat (8) @(posedge sysclk);
    #5;
    rst_n = 1'b1;
    run_test("reset", K_RESET, 1);
    run_test("arith", K_ARITH, N_CYC);
    run_test("dest", K_DEST, N_CYC);
    run_test("status", K_STATUS, N_CYC);
    run_test("bus", K_BUS, N_CYC);
    run_test("pil", K_PIL, N_CYC);
    $display("tests: %0d, checks: %0d, errors: %0d", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
